/* source/exu_defs.svh */
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// data and address width
`define EXU_XLEN 64

// general register count
`define EXU_NREGS 32

// bits to index one register
`define EXU_REG_W 5

// one strobe per byte of a data word
`define EXU_STRB_W 8

// pc step between sequential instructions
`define EXU_INST_BYTES 4

`endif

/* source/exu_pkg.sv */
`default_nettype none

`include "exu_defs.svh"

package exu_pkg;

    // kept instructions
    // nop sits at zero so a cleared stage reads as a bubble
    typedef enum logic [5:0] {
        op_nop,
        op_add, op_sub, op_and, op_or, op_xor,
        op_sll, op_srl, op_sra, op_slt, op_sltu,
        op_addi, op_lui,
        op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
        op_sb, op_sh, op_sw, op_sd
    } op_t;

    // alu operations
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu
    } alu_mode_t;

    // decoded instruction from the decoder, imm already sign-extended
    typedef struct packed {
        op_t                   op;
        logic [`EXU_REG_W-1:0] rd;
        logic [`EXU_REG_W-1:0] rs1;
        logic [`EXU_REG_W-1:0] rs2;
        logic [`EXU_XLEN-1:0]  imm;
        logic [`EXU_XLEN-1:0]  pc;
    } exec_req_t;

    // execute to memory/retire payload
    typedef struct packed {
        op_t                   op;
        logic [`EXU_XLEN-1:0]  pc;
        logic [`EXU_XLEN-1:0]  next_pc;
        logic [`EXU_REG_W-1:0] rd;
        logic                  wen;
        // alu value, link, lui imm or memory address
        logic [`EXU_XLEN-1:0]  result;
        // raw rs2 for stores
        logic [`EXU_XLEN-1:0]  sdata;
    } stage_t;

    // one memory request, wdata already in its byte lanes
    typedef struct packed {
        logic [`EXU_XLEN-1:0]   addr;
        logic [`EXU_XLEN-1:0]   wdata;
        logic [`EXU_STRB_W-1:0] strb;
        logic                   write;
    } mem_req_t;

    // retired instruction as seen outside
    typedef struct packed {
        logic [`EXU_XLEN-1:0]  pc;
        logic [`EXU_XLEN-1:0]  next_pc;
        logic [`EXU_REG_W-1:0] rd;
        logic                  wen;
        logic [`EXU_XLEN-1:0]  wdata;
    } retire_t;

endpackage

`default_nettype wire

/* source/exu_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_alu (
    input  wire exu_pkg::alu_mode_t  mode,
    input  wire [`EXU_XLEN-1:0]      a,
    input  wire [`EXU_XLEN-1:0]      b,
    output logic [`EXU_XLEN-1:0]     y
);

    // rv64 shift amount is the low six bits of b
    logic [5:0] shamt;

    assign shamt = b[5:0];

    always_comb begin
        case (mode)
            exu_pkg::alu_add:  y = a + b;
            // also the eq/ne compare, zero means equal
            exu_pkg::alu_sub:  y = a - b;
            exu_pkg::alu_and:  y = a & b;
            exu_pkg::alu_or:   y = a | b;
            exu_pkg::alu_xor:  y = a ^ b;
            exu_pkg::alu_sll:  y = a << shamt;
            exu_pkg::alu_srl:  y = a >> shamt;
            // arithmetic, sign bit fills from the top
            exu_pkg::alu_sra:  y = $signed(a) >>> shamt;
            // bit 0 carries the compare, reused for blt/bge
            exu_pkg::alu_slt:  y = {{(`EXU_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            // unsigned form for bltu/bgeu
            exu_pkg::alu_sltu: y = {{(`EXU_XLEN-1){1'b0}}, a < b};
            default:           y = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/exu_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_regfile (
    input  wire                    clk,
    input  wire                    rst,
    input  wire [`EXU_REG_W-1:0]   rs1,
    input  wire [`EXU_REG_W-1:0]   rs2,
    output logic [`EXU_XLEN-1:0]   rs1_data,
    output logic [`EXU_XLEN-1:0]   rs2_data,
    input  wire                    wr_en,
    input  wire [`EXU_REG_W-1:0]   wr_idx,
    input  wire [`EXU_XLEN-1:0]    wr_data
);

    logic [`EXU_XLEN-1:0] regs [`EXU_NREGS];

    // x0 never written, so it stays at its reset value of zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `EXU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // async read, a same-edge write is seen next cycle
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

/* source/exu_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_execute (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      in_valid,
    input  wire exu_pkg::exec_req_t  in_req,
    output logic                     in_ready,
    input  wire [`EXU_XLEN-1:0]      rs1_data,
    input  wire [`EXU_XLEN-1:0]      rs2_data,
    input  wire                      busy,
    input  wire [`EXU_REG_W-1:0]     pend_rd,
    output logic                     issue,
    output exu_pkg::stage_t          stage
);

    exu_pkg::alu_mode_t   mode;
    logic [`EXU_XLEN-1:0] opb;
    logic [`EXU_XLEN-1:0] alu_y;
    logic [`EXU_XLEN-1:0] link;
    logic [`EXU_XLEN-1:0] target;
    logic                 taken;
    logic                 hazard;
    exu_pkg::stage_t      next;

    // operand b and alu mode per op, a is always rs1
    always_comb begin
        opb  = rs2_data;
        mode = exu_pkg::alu_add;
        case (in_req.op)
            exu_pkg::op_sub:  mode = exu_pkg::alu_sub;
            exu_pkg::op_and:  mode = exu_pkg::alu_and;
            exu_pkg::op_or:   mode = exu_pkg::alu_or;
            exu_pkg::op_xor:  mode = exu_pkg::alu_xor;
            exu_pkg::op_sll:  mode = exu_pkg::alu_sll;
            exu_pkg::op_srl:  mode = exu_pkg::alu_srl;
            exu_pkg::op_sra:  mode = exu_pkg::alu_sra;
            exu_pkg::op_slt:  mode = exu_pkg::alu_slt;
            exu_pkg::op_sltu: mode = exu_pkg::alu_sltu;
            // branch compares ride on sub and the two set-less-than modes
            exu_pkg::op_beq, exu_pkg::op_bne:   mode = exu_pkg::alu_sub;
            exu_pkg::op_blt, exu_pkg::op_bge:   mode = exu_pkg::alu_slt;
            exu_pkg::op_bltu, exu_pkg::op_bgeu: mode = exu_pkg::alu_sltu;
            // rs1 + imm forms, address or jalr target
            exu_pkg::op_addi, exu_pkg::op_jalr,
            exu_pkg::op_lb, exu_pkg::op_lh, exu_pkg::op_lw, exu_pkg::op_ld,
            exu_pkg::op_lbu, exu_pkg::op_lhu, exu_pkg::op_lwu,
            exu_pkg::op_sb, exu_pkg::op_sh, exu_pkg::op_sw, exu_pkg::op_sd:
                opb = in_req.imm;
            default: ;
        endcase
    end

    exu_alu u_alu (
        .mode (mode),
        .a    (rs1_data),
        .b    (opb),
        .y    (alu_y)
    );

    // branch decision from the alu result
    always_comb begin
        case (in_req.op)
            exu_pkg::op_beq:                    taken = (alu_y == '0);
            exu_pkg::op_bne:                    taken = (alu_y != '0);
            exu_pkg::op_blt, exu_pkg::op_bltu:  taken = alu_y[0];
            exu_pkg::op_bge, exu_pkg::op_bgeu:  taken = !alu_y[0];
            default:                            taken = 1'b0;
        endcase
    end

    // sequential pc doubles as the link value
    assign link   = in_req.pc + `EXU_XLEN'(`EXU_INST_BYTES);
    assign target = in_req.pc + in_req.imm;

    // payload for stage two
    always_comb begin
        next.op      = in_req.op;
        next.pc      = in_req.pc;
        next.rd      = in_req.rd;
        next.sdata   = rs2_data;
        next.next_pc = link;
        next.wen     = 1'b0;
        next.result  = '0;
        case (in_req.op)
            exu_pkg::op_nop: ;
            exu_pkg::op_jal: begin
                next.next_pc = target;
                next.wen     = 1'b1;
                next.result  = link;
            end
            exu_pkg::op_jalr: begin
                // target lsb forced clear
                next.next_pc = {alu_y[`EXU_XLEN-1:1], 1'b0};
                next.wen     = 1'b1;
                next.result  = link;
            end
            exu_pkg::op_lui: begin
                next.wen    = 1'b1;
                next.result = in_req.imm;
            end
            exu_pkg::op_beq, exu_pkg::op_bne, exu_pkg::op_blt,
            exu_pkg::op_bge, exu_pkg::op_bltu, exu_pkg::op_bgeu: begin
                if (taken) begin
                    next.next_pc = target;
                end
            end
            // stores carry only the address
            exu_pkg::op_sb, exu_pkg::op_sh, exu_pkg::op_sw, exu_pkg::op_sd:
                next.result = alu_y;
            // register ops, addi and loads, loads replace the address at retire
            default: begin
                next.wen    = 1'b1;
                next.result = alu_y;
            end
        endcase
    end

    // hold while the retiring instruction still owns a source register
    assign hazard   = (pend_rd != '0) && (in_req.rs1 == pend_rd || in_req.rs2 == pend_rd);
    assign in_ready = !busy && !hazard;
    assign issue    = in_valid && in_ready;

    // stage register, only loaded on an accepted instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= '0;
        end else if (issue) begin
            stage <= next;
        end
    end

endmodule

`default_nettype wire

/* source/exu_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_lsu (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      issue,
    input  wire exu_pkg::stage_t     stage,
    output logic                     busy,
    output logic [`EXU_REG_W-1:0]    pend_rd,
    output logic                     mem_req_valid,
    output exu_pkg::mem_req_t        mem_req,
    input  wire                      mem_req_ready,
    input  wire                      mem_rsp_valid,
    input  wire [`EXU_XLEN-1:0]      mem_rsp_data,
    output logic                     wr_en,
    output logic [`EXU_REG_W-1:0]    wr_idx,
    output logic [`EXU_XLEN-1:0]     wr_data,
    output logic                     retire_valid,
    output exu_pkg::retire_t         retire
);

    // st_req holds any instruction, memory ops also request there
    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_wait
    } state_t;

    state_t                 state;
    logic                   is_load;
    logic                   is_store;
    logic                   is_mem;
    logic [5:0]             lane_shift;
    logic [`EXU_STRB_W-1:0] size_mask;
    logic [`EXU_XLEN-1:0]   store_data;
    logic [`EXU_XLEN-1:0]   lane;
    logic [`EXU_XLEN-1:0]   load_data;

    assign is_load  = stage.op inside {exu_pkg::op_lb, exu_pkg::op_lh, exu_pkg::op_lw,
                                       exu_pkg::op_ld, exu_pkg::op_lbu, exu_pkg::op_lhu,
                                       exu_pkg::op_lwu};
    assign is_store = stage.op inside {exu_pkg::op_sb, exu_pkg::op_sh, exu_pkg::op_sw,
                                       exu_pkg::op_sd};
    assign is_mem   = is_load || is_store;

    // byte offset in the doubleword, as a bit shift
    assign lane_shift = {stage.result[2:0], 3'b000};

    // store size, data trimmed to its width before lane shift
    always_comb begin
        case (stage.op)
            exu_pkg::op_sb: begin
                size_mask  = 8'h01;
                store_data = {{(`EXU_XLEN-8){1'b0}}, stage.sdata[7:0]};
            end
            exu_pkg::op_sh: begin
                size_mask  = 8'h03;
                store_data = {{(`EXU_XLEN-16){1'b0}}, stage.sdata[15:0]};
            end
            exu_pkg::op_sw: begin
                size_mask  = 8'h0f;
                store_data = {{(`EXU_XLEN-32){1'b0}}, stage.sdata[31:0]};
            end
            default: begin
                size_mask  = 8'hff;
                store_data = stage.sdata;
            end
        endcase
    end

    // request stays stable while held in st_req
    assign mem_req_valid = (state == st_req) && is_mem;
    assign mem_req.addr  = stage.result;
    assign mem_req.write = is_store;
    assign mem_req.wdata = is_store ? (store_data << lane_shift) : '0;
    assign mem_req.strb  = is_store ? (size_mask << stage.result[2:0]) : '0;

    // load lane down to bit 0, then extend per op
    assign lane = mem_rsp_data >> lane_shift;

    always_comb begin
        case (stage.op)
            exu_pkg::op_lb:  load_data = {{(`EXU_XLEN-8){lane[7]}}, lane[7:0]};
            exu_pkg::op_lh:  load_data = {{(`EXU_XLEN-16){lane[15]}}, lane[15:0]};
            exu_pkg::op_lw:  load_data = {{(`EXU_XLEN-32){lane[31]}}, lane[31:0]};
            exu_pkg::op_lbu: load_data = {{(`EXU_XLEN-8){1'b0}}, lane[7:0]};
            exu_pkg::op_lhu: load_data = {{(`EXU_XLEN-16){1'b0}}, lane[15:0]};
            exu_pkg::op_lwu: load_data = {{(`EXU_XLEN-32){1'b0}}, lane[31:0]};
            default:         load_data = lane;
        endcase
    end

    // non-memory ops retire the cycle after issue
    // memory ops on their response
    assign retire_valid = ((state == st_req) && !is_mem) ||
                          ((state == st_wait) && mem_rsp_valid);

    // a retiring slot is free for the next issue
    assign busy    = (state != st_idle) && !retire_valid;
    assign pend_rd = ((state != st_idle) && stage.wen) ? stage.rd : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else if (retire_valid) begin
            state <= issue ? st_req : st_idle;
        end else if (issue) begin
            state <= st_req;
        end else if (mem_req_valid && mem_req_ready) begin
            // response comes no earlier than next cycle
            state <= st_wait;
        end
    end

    // writeback, x0 filtered in the register file
    assign wr_data = is_load ? load_data : stage.result;
    assign wr_en   = retire_valid && stage.wen;
    assign wr_idx  = stage.rd;

    assign retire.pc      = stage.pc;
    assign retire.next_pc = stage.next_pc;
    assign retire.rd      = stage.rd;
    assign retire.wen     = stage.wen;
    assign retire.wdata   = wr_data;

endmodule

`default_nettype wire

/* source/exu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_top (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       in_valid,
    input  wire exu_pkg::exec_req_t   in_req,
    output logic                      in_ready,
    output logic                      mem_req_valid,
    output exu_pkg::mem_req_t         mem_req,
    input  wire                       mem_req_ready,
    input  wire                       mem_rsp_valid,
    input  wire [`EXU_XLEN-1:0]       mem_rsp_data,
    output logic                      retire_valid,
    output exu_pkg::retire_t          retire
);

    // register file read data
    logic [`EXU_XLEN-1:0]  rs1_data;
    logic [`EXU_XLEN-1:0]  rs2_data;

    // stage two status back to issue
    logic                  busy;
    logic [`EXU_REG_W-1:0] pend_rd;

    // stage handoff
    logic                  issue;
    exu_pkg::stage_t       stage;

    // writeback port, driven only at retire
    logic                  wr_en;
    logic [`EXU_REG_W-1:0] wr_idx;
    logic [`EXU_XLEN-1:0]  wr_data;

    // indices come straight off the incoming request
    exu_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1      (in_req.rs1),
        .rs2      (in_req.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data)
    );

    exu_execute u_execute (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_req   (in_req),
        .in_ready (in_ready),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .busy     (busy),
        .pend_rd  (pend_rd),
        .issue    (issue),
        .stage    (stage)
    );

    exu_lsu u_lsu (
        .clk           (clk),
        .rst           (rst),
        .issue         (issue),
        .stage         (stage),
        .busy          (busy),
        .pend_rd       (pend_rd),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .wr_en         (wr_en),
        .wr_idx        (wr_idx),
        .wr_data       (wr_data),
        .retire_valid  (retire_valid),
        .retire        (retire)
    );

endmodule

`default_nettype wire

/* verification/exu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_defs.svh"

module exu_tb;

    localparam int clk_period   = 40;
    localparam int rst_cycles   = 8;
    localparam int num_entries  = 54;
    // slowest memory op stays well under 12 cycles
    localparam int watch_cycles = num_entries * 12 + rst_cycles;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 in_valid;
    exu_pkg::exec_req_t   in_req;
    logic                 in_ready;
    logic                 mem_req_valid;
    exu_pkg::mem_req_t    mem_req;
    logic                 mem_req_ready;
    logic                 mem_rsp_valid;
    logic [`EXU_XLEN-1:0] mem_rsp_data;
    logic                 retire_valid;
    exu_pkg::retire_t     retire;

    // stimulus table, one slot per instruction in program order
    string                tbl_name [num_entries];
    exu_pkg::exec_req_t   tbl_req [num_entries];
    exu_pkg::retire_t     tbl_ret [num_entries];
    exu_pkg::mem_req_t    tbl_mem [num_entries];
    logic                 tbl_is_mem [num_entries];
    int                   n_put;
    logic [`EXU_XLEN-1:0] cur_pc;
    logic [`EXU_XLEN-1:0] last_pc;

    // memory model, 16 doublewords indexed by addr[6:3]
    logic [`EXU_XLEN-1:0] mem [16];
    exu_pkg::mem_req_t    req_hold;
    int                   stall;
    int                   delay;
    logic [31:0]          lfsr = 32'hec49;

    // in-order retire, so this also points at the op in stage two
    int                   retire_count;

    exu_top dut (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_req        (in_req),
        .in_ready      (in_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .retire_valid  (retire_valid),
        .retire        (retire)
    );

    always #(clk_period / 2) clk = ~clk;

    // galois lfsr, one step per bit
    function automatic int draw_bits(input int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            v    = (v << 1) | lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // append one entry, next_pc defaults to the sequential pc
    task automatic put(input string name, input exu_pkg::op_t op, input int rd,
                       input int rs1, input int rs2, input logic [63:0] imm,
                       input logic wen, input logic [63:0] wdata);
        exu_pkg::exec_req_t req;
        exu_pkg::retire_t   ret;
        req.op          = op;
        req.rd          = `EXU_REG_W'(rd);
        req.rs1         = `EXU_REG_W'(rs1);
        req.rs2         = `EXU_REG_W'(rs2);
        req.imm         = imm;
        req.pc          = cur_pc;
        ret.pc          = cur_pc;
        ret.next_pc     = cur_pc + `EXU_INST_BYTES;
        ret.rd          = `EXU_REG_W'(rd);
        ret.wen         = wen;
        ret.wdata       = wdata;
        tbl_name[n_put] = name;
        tbl_req[n_put]  = req;
        tbl_ret[n_put]  = ret;
        tbl_mem[n_put]  = '0;
        tbl_is_mem[n_put] = 1'b0;
        last_pc = cur_pc;
        cur_pc  = cur_pc + `EXU_INST_BYTES;
        n_put++;
    endtask

    // redirect the last entry, program flow follows it
    task automatic jump_to(input logic [63:0] npc);
        exu_pkg::retire_t ret;
        ret = tbl_ret[n_put-1];
        ret.next_pc = npc;
        tbl_ret[n_put-1] = ret;
        cur_pc = npc;
    endtask

    task automatic set_mem(input logic [63:0] addr, input logic [63:0] wdata,
                           input logic [7:0] strb, input logic write);
        exu_pkg::mem_req_t m;
        m.addr  = addr;
        m.wdata = wdata;
        m.strb  = strb;
        m.write = write;
        tbl_mem[n_put-1]    = m;
        tbl_is_mem[n_put-1] = 1'b1;
    endtask

    // taken goes to pc+imm, else pc+4
    task automatic put_br(input string name, input exu_pkg::op_t op, input int rs1,
                          input int rs2, input logic [63:0] imm, input logic taken);
        put(name, op, 0, rs1, rs2, imm, 1'b0, '0);
        if (taken) begin
            jump_to(last_pc + imm);
        end
    endtask

    task automatic put_ld(input string name, input exu_pkg::op_t op, input int rd,
                          input logic [63:0] imm, input logic [63:0] addr,
                          input logic [63:0] data);
        put(name, op, rd, 20, 0, imm, 1'b1, data);
        set_mem(addr, '0, '0, 1'b0);
    endtask

    task automatic put_st(input string name, input exu_pkg::op_t op, input int rs2,
                          input logic [63:0] imm, input logic [63:0] addr,
                          input logic [63:0] wdata, input logic [7:0] strb);
        put(name, op, 0, 20, rs2, imm, 1'b0, '0);
        set_mem(addr, wdata, strb, 1'b1);
    endtask

    task automatic build_table();
        // registers all zero out of reset
        put("or_reset", exu_pkg::op_or, 1, 2, 3, 0, 1'b1, 64'h0);
        put("lui_x1", exu_pkg::op_lui, 1, 0, 0, 64'hffff_ffff_8000_0000, 1'b1,
            64'hffff_ffff_8000_0000);
        put("addi_x2", exu_pkg::op_addi, 2, 0, 0, 64'h123, 1'b1, 64'h123);
        put("addi_neg", exu_pkg::op_addi, 3, 0, 0, -64'sd5, 1'b1, -64'sd5);
        put("add", exu_pkg::op_add, 4, 2, 3, 0, 1'b1, 64'h11e);
        put("sub", exu_pkg::op_sub, 5, 2, 3, 0, 1'b1, 64'h128);
        put("and", exu_pkg::op_and, 6, 4, 3, 0, 1'b1, 64'h11a);
        put("or", exu_pkg::op_or, 7, 1, 2, 0, 1'b1, 64'hffff_ffff_8000_0123);
        put("xor", exu_pkg::op_xor, 8, 1, 3, 0, 1'b1, 64'h0000_0000_7fff_fffb);
        put("addi_x9", exu_pkg::op_addi, 9, 0, 0, 64'h4, 1'b1, 64'h4);
        put("sll", exu_pkg::op_sll, 10, 2, 9, 0, 1'b1, 64'h1230);
        put("srl", exu_pkg::op_srl, 11, 1, 9, 0, 1'b1, 64'h0fff_ffff_f800_0000);
        put("sra_neg", exu_pkg::op_sra, 12, 1, 9, 0, 1'b1, 64'hffff_ffff_f800_0000);
        put("slt_neg", exu_pkg::op_slt, 13, 3, 2, 0, 1'b1, 64'h1);
        put("sltu_neg", exu_pkg::op_sltu, 14, 3, 2, 0, 1'b1, 64'h0);
        // x2 = 0x123, x3 = -5
        put_br("beq_t", exu_pkg::op_beq, 2, 2, 64'd16, 1'b1);
        put_br("beq_n", exu_pkg::op_beq, 2, 3, 64'd16, 1'b0);
        put_br("bne_t", exu_pkg::op_bne, 2, 3, 64'd8, 1'b1);
        put_br("bne_n", exu_pkg::op_bne, 2, 2, 64'd8, 1'b0);
        put_br("blt_t", exu_pkg::op_blt, 3, 2, 64'd12, 1'b1);
        put_br("blt_n", exu_pkg::op_blt, 2, 3, 64'd12, 1'b0);
        put_br("bge_t", exu_pkg::op_bge, 2, 3, 64'd32, 1'b1);
        put_br("bge_n", exu_pkg::op_bge, 3, 2, 64'd32, 1'b0);
        put_br("bltu_t", exu_pkg::op_bltu, 2, 3, -64'sd8, 1'b1);
        put_br("bltu_n", exu_pkg::op_bltu, 3, 2, -64'sd8, 1'b0);
        put_br("bgeu_t", exu_pkg::op_bgeu, 3, 2, 64'd20, 1'b1);
        put_br("bgeu_n", exu_pkg::op_bgeu, 2, 3, 64'd20, 1'b0);
        // links write pc+4
        put("jal", exu_pkg::op_jal, 15, 0, 0, 64'h40, 1'b1, cur_pc + 4);
        jump_to(last_pc + 64'h40);
        // 0x123 + 0x10, bit 0 cleared
        put("jalr", exu_pkg::op_jalr, 16, 2, 0, 64'h10, 1'b1, cur_pc + 4);
        jump_to(64'h132);
        put("jalr_x0", exu_pkg::op_jalr, 0, 9, 0, 64'h1000, 1'b1, cur_pc + 4);
        jump_to(64'h1004);
        // store base and data
        put("addi_base", exu_pkg::op_addi, 20, 0, 0, 64'h40, 1'b1, 64'h40);
        // x0 read one op later, after the jalr_x0 write edge
        put("x0_zero", exu_pkg::op_add, 17, 0, 9, 0, 1'b1, 64'h4);
        put("lui_x21", exu_pkg::op_lui, 21, 0, 0, 64'hffff_ffff_8765_4000, 1'b1,
            64'hffff_ffff_8765_4000);
        put("addi_x21", exu_pkg::op_addi, 21, 21, 0, 64'h321, 1'b1, 64'hffff_ffff_8765_4321);
        put_st("sd_0", exu_pkg::op_sd, 21, 64'h0, 64'h40, 64'hffff_ffff_8765_4321, 8'hff);
        put_st("sw_12", exu_pkg::op_sw, 2, 64'hc, 64'h4c, 64'h0000_0123_0000_0000, 8'hf0);
        put_st("sh_2", exu_pkg::op_sh, 3, 64'h2, 64'h42, 64'h0000_0000_fffb_0000, 8'h0c);
        put_st("sb_7", exu_pkg::op_sb, 2, 64'h7, 64'h47, 64'h2300_0000_0000_0000, 8'h80);
        put_st("sb_11", exu_pkg::op_sb, 3, 64'h11, 64'h51, 64'h0000_0000_0000_fb00, 8'h02);
        // doubleword at 0x40 now reads 23ff_ffff_fffb_4321
        put_ld("ld_0", exu_pkg::op_ld, 24, 64'h0, 64'h40, 64'h23ff_ffff_fffb_4321);
        put_ld("lw_0", exu_pkg::op_lw, 25, 64'h0, 64'h40, 64'hffff_ffff_fffb_4321);
        put_ld("lwu_0", exu_pkg::op_lwu, 26, 64'h0, 64'h40, 64'h0000_0000_fffb_4321);
        put_ld("lh_2", exu_pkg::op_lh, 27, 64'h2, 64'h42, 64'hffff_ffff_ffff_fffb);
        put_ld("lhu_2", exu_pkg::op_lhu, 28, 64'h2, 64'h42, 64'h0000_0000_0000_fffb);
        put_ld("lb_7", exu_pkg::op_lb, 29, 64'h7, 64'h47, 64'h23);
        put_ld("lbu_11", exu_pkg::op_lbu, 30, 64'h11, 64'h51, 64'hfb);
        put_ld("lb_11", exu_pkg::op_lb, 31, 64'h11, 64'h51, 64'hffff_ffff_ffff_fffb);
        put_ld("lw_12", exu_pkg::op_lw, 18, 64'hc, 64'h4c, 64'h123);
        put_ld("lh_4", exu_pkg::op_lh, 19, 64'h4, 64'h44, 64'hffff_ffff_ffff_ffff);
        // dependent chain through memory
        put_ld("ld_chain", exu_pkg::op_ld, 5, 64'h0, 64'h40, 64'h23ff_ffff_fffb_4321);
        put("add_chain", exu_pkg::op_add, 6, 5, 5, 0, 1'b1, 64'h47ff_ffff_fff6_8642);
        put_st("sd_chain", exu_pkg::op_sd, 6, 64'h8, 64'h48, 64'h47ff_ffff_fff6_8642, 8'hff);
        put_ld("ld_back", exu_pkg::op_ld, 7, 64'h8, 64'h48, 64'h47ff_ffff_fff6_8642);
        put("sub_chain", exu_pkg::op_sub, 8, 7, 6, 0, 1'b1, 64'h0);
    endtask

    task automatic check_retire(input string name, input exu_pkg::retire_t exp,
                                input exu_pkg::retire_t act);
        // rd and wdata carry meaning only for a writing op
        if (!exp.wen) begin
            exp.rd    = '0;
            exp.wdata = '0;
            act.rd    = '0;
            act.wdata = '0;
        end
        if (act !== exp) begin
            $display("CHECK FAILED %s retire: expected %h actual %h", name, exp, act);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_mem_req(input string name, input exu_pkg::mem_req_t exp,
                                 input exu_pkg::mem_req_t act);
        // loads leave data and strobes unused
        if (!exp.write) begin
            exp.wdata = '0;
            exp.strb  = '0;
            act.wdata = '0;
            act.strb  = '0;
        end
        if (act !== exp) begin
            $display("CHECK FAILED %s mem_req: expected %h actual %h", name, exp, act);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    // outputs sampled mid-cycle, inputs only move on rising edges
    always @(negedge clk) begin
        if (!rst) begin
            if (mem_req_valid) begin
                if (retire_count >= num_entries || !tbl_is_mem[retire_count]) begin
                    $display("memory request raised with no load or store in stage two");
                    $display("Test FAILED");
                    $fatal(1);
                end else begin
                    check_mem_req(tbl_name[retire_count], tbl_mem[retire_count], mem_req);
                end
            end
            if (retire_valid) begin
                if (retire_count >= num_entries) begin
                    $display("retire seen after every table entry had retired");
                    $display("Test FAILED");
                    $fatal(1);
                end else begin
                    check_retire(tbl_name[retire_count], tbl_ret[retire_count], retire);
                    retire_count++;
                end
            end
        end
    end

    // ready after 0..3 stall cycles, response 0..3 cycles after the transfer
    always begin : mem_model
        @(negedge clk);
        if (!rst && mem_req_valid) begin
            req_hold = mem_req;
            stall = draw_bits(2);
            repeat (stall) @(posedge clk);
            @(posedge clk);
            mem_req_ready <= 1'b1;
            // transfer edge
            @(posedge clk);
            mem_req_ready <= 1'b0;
            delay = draw_bits(2);
            repeat (delay) @(posedge clk);
            @(posedge clk);
            mem_rsp_valid <= 1'b1;
            mem_rsp_data  <= mem[req_hold.addr[6:3]];
            if (req_hold.write) begin
                for (int b = 0; b < `EXU_STRB_W; b++) begin
                    if (req_hold.strb[b]) begin
                        mem[req_hold.addr[6:3]][b*8 +: 8] = req_hold.wdata[b*8 +: 8];
                    end
                end
            end
            @(posedge clk);
            mem_rsp_valid <= 1'b0;
        end
    end

    initial begin : watchdog
        #(watch_cycles * clk_period);
        $display("watchdog expired, no retire arrived in time");
        $display("Test FAILED");
        $fatal(1);
    end

    initial begin : main
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_req        = '0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        retire_count  = 0;
        n_put         = 0;
        cur_pc        = 64'h1000;
        last_pc       = 64'h1000;
        // fill differs for every doubleword
        for (int i = 0; i < 16; i++) begin
            mem[i] = {16{4'(i)}} ^ 64'ha5a5_5a5a_0f0f_f0f0;
        end
        build_table();
        if (n_put != num_entries) begin
            $display("stimulus table holds %0d entries, %0d expected", n_put, num_entries);
            $display("Test FAILED");
            $fatal(1);
        end
        repeat (rst_cycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (!in_ready || retire_valid || mem_req_valid) begin
            $display("handshake outputs wrong right after reset");
            $display("Test FAILED");
            $fatal(1);
        end
        @(posedge clk);
        // entry held until in_ready, accepted on the following edge
        for (int i = 0; i < num_entries; i++) begin
            in_valid <= 1'b1;
            in_req   <= tbl_req[i];
            @(negedge clk);
            while (!in_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
        end
        in_valid <= 1'b0;
        wait (retire_count == num_entries);
        @(negedge clk);
        if (retire_valid || mem_req_valid || !in_ready) begin
            $display("DUT not idle after the last retire");
            $display("Test FAILED");
            $fatal(1);
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+source
source/exu_pkg.sv
source/exu_alu.sv
source/exu_regfile.sv
source/exu_execute.sv
source/exu_lsu.sv
source/exu_top.sv
verification/exu_tb.sv
